//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int CACHE_ADDR_W = 25;  // word address towards the data cache
    localparam int CACHE_BYTE_W = 4;

    // opcodes of the kept instruction classes
    localparam logic [6:0] OPC_ALU_I  = 7'b0010011;
    localparam logic [6:0] OPC_ALU_R  = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu funct3, shared by the I and R forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;

    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } inst_s_t;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } inst_b_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
    } inst_u;

endpackage

`default_nettype wire

//--- ex_decode.sv
`default_nettype none

module ex_decode (
    input  ex_pkg::inst_u                 inst_i,
    output logic                          is_alu_imm_o,
    output logic                          is_alu_reg_o,
    output logic                          is_branch_o,
    output logic                          is_load_o,
    output logic                          is_store_o,
    output logic                          alu_ok_o,
    output logic [2:0]                    funct3_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [ex_pkg::XLEN-1:0]       imm_o
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic       br_f3_ok;
    logic       ld_f3_ok;
    logic       st_f3_ok;
    logic       shift_imm;

    // opcode, funct3 and rd sit at the same place in every view
    assign opcode   = inst_i.r.opcode;
    assign f3       = inst_i.r.funct3;
    assign funct3_o = f3;
    assign rd_o     = inst_i.r.rd;

    assign br_f3_ok = f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    assign ld_f3_ok = f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
    assign st_f3_ok = f3 inside {F3_SB, F3_SH, F3_SW};

    assign is_alu_imm_o = (opcode == OPC_ALU_I);
    assign is_alu_reg_o = (opcode == OPC_ALU_R);
    assign is_branch_o  = (opcode == OPC_BRANCH) && br_f3_ok;
    assign is_load_o    = (opcode == OPC_LOAD) && ld_f3_ok;
    assign is_store_o   = (opcode == OPC_STORE) && st_f3_ok;

    assign shift_imm = is_alu_imm_o && ((f3 == F3_SLL) || (f3 == F3_SRL));

    // no sub / sra here, so any funct7 bit set means unsupported
    always_comb begin
        if (is_alu_reg_o) begin
            alu_ok_o = (inst_i.r.funct7 == 7'd0);
        end else if (shift_imm) begin
            alu_ok_o = (inst_i.i.imm[11:5] == 7'd0);  // srai lands here
        end else begin
            alu_ok_o = 1'b1;
        end
    end

    always_comb begin
        case (opcode)
            OPC_ALU_I, OPC_LOAD: begin
                imm_o = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
            end
            OPC_STORE: begin
                imm_o = {{(XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
            end
            OPC_BRANCH: begin
                imm_o = {{(XLEN-13){inst_i.b.imm12}},
                         inst_i.b.imm12,
                         inst_i.b.imm11,
                         inst_i.b.imm10_5,
                         inst_i.b.imm4_1,
                         1'b0};
            end
            default: begin
                imm_o = '0;  // r-type and the rest
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ex_alu.sv
`default_nettype none

module ex_alu (
    input  logic [ex_pkg::XLEN-1:0] a_i,
    input  logic [ex_pkg::XLEN-1:0] b_i,
    input  logic [2:0]              funct3_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);
    import ex_pkg::*;

    logic            lt_s;
    logic            lt_u;
    logic [4:0]      shamt;

    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign shamt = b_i[4:0];  // only the low five bits count

    always_comb begin
        case (funct3_i)
            F3_ADD: begin
                result_o = a_i + b_i;
            end
            F3_SLL: begin
                result_o = a_i << shamt;
            end
            F3_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            end
            F3_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            F3_XOR: begin
                result_o = a_i ^ b_i;
            end
            F3_SRL: begin
                result_o = a_i >> shamt;  // logical only
            end
            F3_OR: begin
                result_o = a_i | b_i;
            end
            F3_AND: begin
                result_o = a_i & b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ex_branch.sv
`default_nettype none

module ex_branch (
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [2:0]              funct3_i,
    input  logic                    is_branch_i,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);
    import ex_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o  = is_branch_i & cond;
    assign target_o = pc_i + imm_i;  // pc relative

endmodule

`default_nettype wire

//--- ex_lsu_req.sv
`default_nettype none

module ex_lsu_req (
    input  logic [ex_pkg::XLEN-1:0]         rs1_i,
    input  logic [ex_pkg::XLEN-1:0]         rs2_i,
    input  logic [ex_pkg::XLEN-1:0]         imm_i,
    input  logic [2:0]                      funct3_i,
    input  logic                            is_load_i,
    input  logic                            is_store_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]   rd_i,
    output logic [ex_pkg::CACHE_ADDR_W-1:0] addr_o,
    output logic [ex_pkg::CACHE_BYTE_W-1:0] byte_en_o,
    output logic [ex_pkg::XLEN-1:0]         wdata_o,
    output logic                            read_o,
    output logic                            write_o,
    output logic                            hold_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]   load_rd_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]         ea;
    logic [1:0]              off;
    logic [CACHE_ADDR_W-1:0] word_addr;

    assign ea        = rs1_i + imm_i;
    assign off       = ea[1:0];
    assign word_addr = {{(CACHE_ADDR_W-21){1'b0}}, ea[22:2]};  // 8 MiB window

    always_comb begin
        addr_o    = '0;
        byte_en_o = '0;
        wdata_o   = '0;
        read_o    = 1'b0;
        write_o   = 1'b0;
        hold_o    = 1'b0;
        load_rd_o = '0;
        if (is_load_i) begin
            addr_o    = word_addr;
            read_o    = 1'b1;
            hold_o    = 1'b1;  // stall until the data comes back
            load_rd_o = rd_i;
        end else if (is_store_i) begin
            addr_o  = word_addr;
            write_o = 1'b1;
            case (funct3_i)
                F3_SB: begin
                    byte_en_o = 4'b0001 << off;
                    wdata_o   = rs2_i << {off, 3'b000};
                end
                F3_SH: begin
                    byte_en_o = off[1] ? 4'b1100 : 4'b0011;
                    wdata_o   = rs2_i << {off[1], 4'b0000};
                end
                F3_SW: begin
                    byte_en_o = {CACHE_BYTE_W{1'b1}};
                    wdata_o   = rs2_i;
                end
                default: begin
                    write_o = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [ex_pkg::XLEN-1:0]         inst_i,
    input  logic [ex_pkg::XLEN-1:0]         inst_addr_i,
    input  logic [ex_pkg::XLEN-1:0]         reg1_rdata_i,
    input  logic [ex_pkg::XLEN-1:0]         reg2_rdata_i,
    output logic                            reg_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]   reg_waddr_o,
    output logic [ex_pkg::XLEN-1:0]         reg_wdata_o,
    output logic                            jump_flag_o,
    output logic [ex_pkg::XLEN-1:0]         jump_addr_o,
    output logic [ex_pkg::CACHE_ADDR_W-1:0] mem_addr_o,
    output logic [ex_pkg::CACHE_BYTE_W-1:0] mem_byte_en_o,
    output logic [ex_pkg::XLEN-1:0]         mem_wdata_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o,
    output logic                            hold_flag_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]   load_rd_o
);
    import ex_pkg::*;

    logic                    is_alu_imm;
    logic                    is_alu_reg;
    logic                    is_branch;
    logic                    is_load;
    logic                    is_store;
    logic                    alu_ok;
    logic [2:0]              funct3;
    logic [REG_ADDR_W-1:0]   rd;
    logic [XLEN-1:0]         imm;
    logic [XLEN-1:0]         alu_b;
    logic [XLEN-1:0]         alu_result;
    logic                    wb_we;
    logic                    br_taken;
    logic [XLEN-1:0]         br_target;
    logic [CACHE_ADDR_W-1:0] lsu_addr;
    logic [CACHE_BYTE_W-1:0] lsu_byte_en;
    logic [XLEN-1:0]         lsu_wdata;
    logic                    lsu_read;
    logic                    lsu_write;
    logic                    lsu_hold;
    logic [REG_ADDR_W-1:0]   lsu_load_rd;

    ex_decode u_decode (
        .inst_i       (inst_i),
        .is_alu_imm_o (is_alu_imm),
        .is_alu_reg_o (is_alu_reg),
        .is_branch_o  (is_branch),
        .is_load_o    (is_load),
        .is_store_o   (is_store),
        .alu_ok_o     (alu_ok),
        .funct3_o     (funct3),
        .rd_o         (rd),
        .imm_o        (imm)
    );

    assign alu_b = is_alu_imm ? imm : reg2_rdata_i;

    ex_alu u_alu (
        .a_i      (reg1_rdata_i),
        .b_i      (alu_b),
        .funct3_i (funct3),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .rs1_i       (reg1_rdata_i),
        .rs2_i       (reg2_rdata_i),
        .imm_i       (imm),
        .pc_i        (inst_addr_i),
        .funct3_i    (funct3),
        .is_branch_i (is_branch),
        .taken_o     (br_taken),
        .target_o    (br_target)
    );

    ex_lsu_req u_lsu_req (
        .rs1_i      (reg1_rdata_i),
        .rs2_i      (reg2_rdata_i),
        .imm_i      (imm),
        .funct3_i   (funct3),
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .rd_i       (rd),
        .addr_o     (lsu_addr),
        .byte_en_o  (lsu_byte_en),
        .wdata_o    (lsu_wdata),
        .read_o     (lsu_read),
        .write_o    (lsu_write),
        .hold_o     (lsu_hold),
        .load_rd_o  (lsu_load_rd)
    );

    // x0 writes go out too, the regfile drops them
    assign wb_we = (is_alu_imm | is_alu_reg) & alu_ok;

    // EX/MEM boundary
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_we_o      <= 1'b0;
            reg_waddr_o   <= '0;
            reg_wdata_o   <= '0;
            jump_flag_o   <= 1'b0;
            jump_addr_o   <= '0;
            mem_addr_o    <= '0;
            mem_byte_en_o <= '0;
            mem_wdata_o   <= '0;
            mem_read_o    <= 1'b0;
            mem_write_o   <= 1'b0;
            hold_flag_o   <= 1'b0;
            load_rd_o     <= '0;
        end else begin
            reg_we_o      <= wb_we;
            reg_waddr_o   <= wb_we ? rd : '0;
            reg_wdata_o   <= wb_we ? alu_result : '0;
            jump_flag_o   <= br_taken;
            jump_addr_o   <= br_taken ? br_target : '0;
            mem_addr_o    <= lsu_addr;
            mem_byte_en_o <= lsu_byte_en;
            mem_wdata_o   <= lsu_wdata;
            mem_read_o    <= lsu_read;
            mem_write_o   <= lsu_write;
            hold_flag_o   <= lsu_hold;  // advisory only
            load_rd_o     <= lsu_load_rd;
        end
    end

endmodule

`default_nettype wire

//--- tb_ex_checks.svh
// bounded wait for the next rising edge
task automatic wait_rise;
    int unsigned start;
    int          guard;
    start = rise_cnt;
    guard = 0;
    while (rise_cnt == start) begin
        @(posedge clk);
        guard++;
        if (guard > TIMEOUT_CYC) fail_run("Timeout: no rising clock edge seen");
    end
endtask

// result of the edge after issue, sampled mid cycle
task automatic wait_result(input int unsigned issue);
    int guard;
    guard = 0;
    while (rise_cnt <= issue) begin
        @(negedge clk);
        guard++;
        if (guard > TIMEOUT_CYC) fail_run("Timeout: registered result never arrived");
    end
endtask

task automatic drive_inst(input logic [31:0] in, input logic [31:0] pcv,
                          input logic [31:0] a, input logic [31:0] b,
                          output int unsigned issue);
    wait_rise();
    inst    <= in;
    pc      <= pcv;
    rs1_val <= a;
    rs2_val <= b;
    issue = rise_cnt;
endtask

task automatic run_inst(input logic [31:0] in, input logic [31:0] pcv,
                        input logic [31:0] a, input logic [31:0] b);
    int unsigned issue;
    drive_inst(in, pcv, a, b, issue);
    model(in, pcv, a, b);
    wait_result(issue);
    check_outputs();
endtask

task automatic reset_sequence;
    int unsigned issue;
    for (int k = 0; k < 2; k++) begin
        // addi x3 held in reset must not show up
        drive_inst({12'd5, 5'd1, 3'b000, 5'd3, 7'b0010011}, next_rand(), next_rand(),
                   next_rand(), issue);
        model('0, '0, '0, '0);
        wait_result(issue);
        check_outputs();
    end
    drive_inst('0, '0, '0, '0, issue);
    reset_i <= 1'b0;
    wait_result(issue);
    check_outputs();
endtask

task automatic alu_imm_ops;
    logic [31:0] r;
    logic [11:0] imm;
    for (int f = 0; f < 8; f++) begin
        r   = next_rand();
        imm = (f == 1 || f == 5) ? {7'd0, r[4:0]} : r[31:20];
        run_inst({imm, 5'd1, 3'(f), r[11:7], 7'b0010011}, next_rand(), next_rand(), 32'd0);
    end
    run_inst({7'b0100000, 5'd3, 5'd1, 3'b101, 5'd4, 7'b0010011}, 32'd0, next_rand(), 32'd0);
    run_inst({7'b0000001, 5'd3, 5'd1, 3'b001, 5'd4, 7'b0010011}, 32'd0, next_rand(), 32'd0);
endtask

task automatic alu_reg_ops;
    logic [31:0] lhs [4];
    logic [31:0] rhs [4];
    lhs = '{32'h8000_0000, 32'd1, 32'hFFFF_FFFF, 32'h7FFF_FFFF};
    rhs = '{32'd1, 32'h8000_0000, 32'd0, 32'h8000_0000};
    for (int f = 0; f < 8; f++) begin
        run_inst({7'd0, 5'd2, 5'd1, 3'(f), 5'(f + 5), 7'b0110011}, 32'd0, next_rand(), next_rand());
    end
    foreach (lhs[p]) begin
        run_inst({7'd0, 5'd2, 5'd1, 3'b010, 5'd6, 7'b0110011}, 32'd0, lhs[p], rhs[p]);
        run_inst({7'd0, 5'd2, 5'd1, 3'b011, 5'd7, 7'b0110011}, 32'd0, lhs[p], rhs[p]);
    end
    run_inst({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd8, 7'b0110011}, 32'd0, 32'd9, 32'd4);  // sub
endtask

task automatic branch_conditions;
    logic [31:0] lhs [5];
    logic [31:0] rhs [5];
    logic [2:0]  conds [7];
    logic [31:0] r;
    lhs   = '{32'd7, 32'hFFFF_FFFB, 32'd3, 32'd2, 32'd9};
    rhs   = '{32'd7, 32'd3, 32'hFFFF_FFFB, 32'd9, 32'd2};
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111, 3'b010};
    foreach (conds[c]) begin
        foreach (lhs[p]) begin
            r = next_rand();
            run_inst({r[31:25], 5'd2, 5'd1, conds[c], r[11:7], 7'b1100011},
                     next_rand() & 32'hFFFF_FFFC, lhs[p], rhs[p]);
        end
    end
endtask

task automatic store_load_requests;
    logic [31:0] r;
    logic [2:0]  loads [6];
    loads = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b011};  // last one is invalid
    for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off++) begin
            r = next_rand();
            run_inst({r[31:25], 5'd2, 5'd1, 3'(s), r[11:9], 2'b00, 7'b0100011}, 32'd0,
                     (next_rand() & 32'hFFFF_FFFC) | 32'(off), next_rand());
        end
    end
    foreach (loads[i]) begin
        r = next_rand();
        run_inst({r[31:20], 5'd1, loads[i], r[11:7], 7'b0000011}, 32'd0, next_rand(), next_rand());
    end
endtask

task automatic unsupported_opcodes;
    logic [6:0]  opcs [4];
    logic [31:0] r;
    opcs = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b0001111};  // lui auipc jal fence
    foreach (opcs[i]) begin
        r = next_rand();
        run_inst({r[31:7], opcs[i]}, next_rand(), next_rand(), next_rand());
    end
endtask

//--- tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int TIMEOUT_CYC = 20;

    logic                    clk = 1'b0;
    int unsigned             rise_cnt = 0;
    logic [31:0]             rng_state = 32'd4907;
    logic                    reset_i;
    logic [XLEN-1:0]         inst;
    logic [XLEN-1:0]         pc;
    logic [XLEN-1:0]         rs1_val;
    logic [XLEN-1:0]         rs2_val;
    logic                    reg_we, jump_flag, mem_read, mem_write, hold_flag;
    logic [REG_ADDR_W-1:0]   reg_waddr, load_rd;
    logic [XLEN-1:0]         reg_wdata, jump_addr, mem_wdata;
    logic [CACHE_ADDR_W-1:0] mem_addr;
    logic [CACHE_BYTE_W-1:0] mem_byte_en;

    // expected register stage contents
    logic                    exp_we, exp_jump, exp_read, exp_write, exp_hold;
    logic [REG_ADDR_W-1:0]   exp_waddr, exp_lrd;
    logic [XLEN-1:0]         exp_wdata, exp_jaddr, exp_wd;
    logic [CACHE_ADDR_W-1:0] exp_maddr;
    logic [CACHE_BYTE_W-1:0] exp_be;

    ex_stage dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_i        (inst),
        .inst_addr_i   (pc),
        .reg1_rdata_i  (rs1_val),
        .reg2_rdata_i  (rs2_val),
        .reg_we_o      (reg_we),
        .reg_waddr_o   (reg_waddr),
        .reg_wdata_o   (reg_wdata),
        .jump_flag_o   (jump_flag),
        .jump_addr_o   (jump_addr),
        .mem_addr_o    (mem_addr),
        .mem_byte_en_o (mem_byte_en),
        .mem_wdata_o   (mem_wdata),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .hold_flag_o   (hold_flag),
        .load_rd_o     (load_rd)
    );

    initial begin
        forever begin
            #2;
            if (!clk) rise_cnt++;  // counted before the edge, waiters see it
            clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] want);
        assert (got === want) else begin
            fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h (inst %h)",
                               $time, what, got, want, inst));
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'd0: return a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model(input logic [31:0] in, input logic [31:0] pcv,
                         input logic [31:0] a, input logic [31:0] b);
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] ea;
        logic        ok;
        logic        cond;
        f3    = in[14:12];
        imm_i = {{20{in[31]}}, in[31:20]};
        imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
        imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        {exp_we, exp_waddr, exp_wdata, exp_jump, exp_jaddr} = '0;
        {exp_maddr, exp_be, exp_wd, exp_read, exp_write, exp_hold, exp_lrd} = '0;
        case (in[6:0])
            7'b0010011, 7'b0110011: begin
                if (in[5]) begin
                    ok = (in[31:25] == 7'd0);
                end else begin
                    // shift immediates only carry a shamt
                    ok = (f3 == 3'b001 || f3 == 3'b101) ? (in[31:25] == 7'd0) : 1'b1;
                end
                exp_we    = ok;
                exp_waddr = ok ? in[11:7] : 5'd0;
                exp_wdata = ok ? alu_ref(f3, a, in[5] ? b : imm_i) : 32'd0;
            end
            7'b1100011: begin
                case (f3)
                    3'b000: cond = (a == b);
                    3'b001: cond = (a != b);
                    3'b100: cond = ($signed(a) < $signed(b));
                    3'b101: cond = ($signed(a) >= $signed(b));
                    3'b110: cond = (a < b);
                    3'b111: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                exp_jump  = cond;
                exp_jaddr = cond ? pcv + imm_b : 32'd0;
            end
            7'b0000011: begin
                if (f3 != 3'b011 && f3 < 3'b110) begin
                    ea        = a + imm_i;
                    exp_maddr = {4'd0, ea[22:2]};
                    exp_read  = 1'b1;
                    exp_hold  = 1'b1;
                    exp_lrd   = in[11:7];
                end
            end
            7'b0100011: begin
                ea = a + imm_s;
                if (f3 <= 3'b010) begin
                    exp_maddr = {4'd0, ea[22:2]};
                    exp_write = 1'b1;
                end
                case (f3)
                    3'b000: begin
                        exp_be = 4'b0001 << ea[1:0];
                        exp_wd = b << (8 * ea[1:0]);
                    end
                    3'b001: begin
                        exp_be = ea[1] ? 4'b1100 : 4'b0011;
                        exp_wd = ea[1] ? b << 16 : b;
                    end
                    3'b010: begin
                        exp_be = 4'b1111;
                        exp_wd = b;
                    end
                    default: ;
                endcase
            end
            default: ;  // everything else is a bubble
        endcase
    endtask

    task automatic check_outputs;
        check_val("reg_we_o", 32'(reg_we), 32'(exp_we));
        check_val("reg_waddr_o", 32'(reg_waddr), 32'(exp_waddr));
        check_val("reg_wdata_o", reg_wdata, exp_wdata);
        check_val("jump_flag_o", 32'(jump_flag), 32'(exp_jump));
        check_val("jump_addr_o", jump_addr, exp_jaddr);
        check_val("mem_addr_o", 32'(mem_addr), 32'(exp_maddr));
        check_val("mem_byte_en_o", 32'(mem_byte_en), 32'(exp_be));
        check_val("mem_wdata_o", mem_wdata, exp_wd);
        check_val("mem_read_o", 32'(mem_read), 32'(exp_read));
        check_val("mem_write_o", 32'(mem_write), 32'(exp_write));
        check_val("hold_flag_o", 32'(hold_flag), 32'(exp_hold));
        check_val("load_rd_o", 32'(load_rd), 32'(exp_lrd));
    endtask

    `include "tb_ex_checks.svh"

    initial begin
        reset_i = 1'b1;
        inst    = '0;
        pc      = '0;
        rs1_val = '0;
        rs2_val = '0;
        reset_sequence();
        alu_imm_ops();
        alu_reg_ops();
        branch_conditions();
        store_load_requests();
        unsupported_opcodes();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_lsu_req.sv
ex_stage.sv
tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f verilog.f -o sim_ex_stage

out=$(./obj_dir/sim_ex_stage 2>&1) || true
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"
